// ==== fadeFx.f ====
src/fadePkg.sv
src/frameCounter.sv
src/fadeCsr.sv
src/sceneChange.sv
src/alphaBlend.sv
src/fadeTop.sv
verif/fadeTop_assert.sv
verif/fadeTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the fade overlay testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module fadeTb -Mdir obj_dir -f fadeFx.f

simStatus=0
./obj_dir/VfadeTb > sim.log 2>&1 || simStatus=$?
cat sim.log

if [ "$simStatus" -ne 0 ] || grep -q "Simulation finished: FAIL" sim.log; then
	exit 1
fi

// ==== verif/fadeTb.sv ====
// --------------------
// Fade overlay testbench
// Host writes, table of fade tests, pixel stream with
// per-pixel blend check and status readback
// --------------------
`timescale 1ns/1ps

module fadeTb;

	import fadePkg::*;

	localparam int cH        = 8;
	localparam int cV        = 4;
	localparam int cFramePix = cH * cV;   // 32 pixels per frame
	localparam int cTests    = 4;

	logic        iCLK;
	logic        rstN;
	logic        iCsrWe;
	csrAddr_e    iCsrAddr;
	csrData_u    iCsrWdata;
	logic [15:0] oCsrRdata;
	logic        iSrcValid;
	argb_t       iSrcPixel;
	logic        oValid;
	argb_t       oPixel;

	// Test table
	string       tName [cTests];
	logic [15:0] tColor [cTests];
	logic [15:0] tCtrl [cTests];
	int          tFrames [cTests];
	logic [3:0]  tAlpha [cTests];
	logic        tMax [cTests];
	logic        tMin [cTests];

	argb_t       expQ [$];        // Pixels in flight
	logic [31:0] rngState = 32'd21;
	logic [3:0]  modelAlpha;      // Alpha tracked by the step rule
	int          modelCnt;
	int          errCnt = 0;
	int          passCnt = 0;
	int          failCnt = 0;
	int          cycleCnt = 0;
	int          cycleLimit = 0;

	fadeTop #(
		.pHActive (cH),
		.pVActive (cV)
	) i_fadeTop (
		.iCLK      (iCLK),
		.rstN      (rstN),
		.iCsrWe    (iCsrWe),
		.iCsrAddr  (iCsrAddr),
		.iCsrWdata (iCsrWdata),
		.oCsrRdata (oCsrRdata),
		.iSrcValid (iSrcValid),
		.iSrcPixel (iSrcPixel),
		.oValid    (oValid),
		.oPixel    (oPixel)
	);

	initial
	begin
		iCLK = 1'b0;
		forever #5 iCLK = ~iCLK;
	end

	// --------------------
	// Helpers
	function automatic logic [31:0] nextRandom(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Per channel (a*scene + (15-a)*src) >> 4 with opaque alpha
	function automatic argb_t blendPixel(input logic [3:0] a, input argb_t scene,
		input argb_t src);
		argb_t res;
		int    aw;
		int    ai;
		aw        = a;
		ai        = 15 - aw;
		res.alpha = 4'd15;
		res.red   = 4'((aw * scene.red + ai * src.red) >> 4);
		res.green = 4'((aw * scene.green + ai * src.green) >> 4);
		res.blue  = 4'((aw * scene.blue + ai * src.blue) >> 4);
		return res;
	endfunction

	task automatic checkVal(input string sigName, input logic [15:0] expV,
		input logic [15:0] gotV);
		if (gotV !== expV)
		begin
			errCnt++;
			$display("[ERROR] %0t %s expected %h got %h", $time, sigName, expV, gotV);
		end
	endtask

	task automatic writeReg(input csrAddr_e addr, input logic [15:0] data);
		@(posedge iCLK);
		#1;
		iCsrWe    = 1'b1;
		iCsrAddr  = addr;
		iCsrWdata = data;
		@(posedge iCLK);
		#1 iCsrWe = 1'b0;
	endtask

	// Data returns one cycle after the address
	task automatic readReg(input csrAddr_e addr, output logic [15:0] data);
		@(posedge iCLK);
		#1 iCsrAddr = addr;
		@(posedge iCLK);
		#1 data = oCsrRdata;
	endtask

	// Step rule at frame end where add wins over sub and alpha saturates
	task automatic stepModel(input fadeCtrl_t c);
		if (!c.sceneRst && (c.addEn || c.subEn))
		begin
			if (modelCnt == int'(c.frameTiming))
			begin
				modelCnt = 0;
				if (c.addEn && modelAlpha != 4'd15)
					modelAlpha = modelAlpha + 4'd1;
				else if (!c.addEn && modelAlpha != 4'd0)
					modelAlpha = modelAlpha - 4'd1;
			end
			else
				modelCnt++;
		end
	endtask

	// --------------------
	// Pixel driver with back to back strobes
	task automatic streamFrames(input int nFrames, input fadeCtrl_t c, input argb_t color);
		argb_t src;
		for (int f = 0; f < nFrames; f++)
		begin
			for (int p = 0; p < cFramePix; p++)
			begin
				@(posedge iCLK);
				#1;
				rngState  = nextRandom(rngState);
				src       = rngState[15:0];
				iSrcValid = 1'b1;
				iSrcPixel = src;
				expQ.push_back(blendPixel(modelAlpha, color, src));
			end
			stepModel(c);    // Last pixel still saw the old alpha
		end
		@(posedge iCLK);
		#1 iSrcValid = 1'b0;
		while (expQ.size() != 0)
			@(posedge iCLK);   // Wait for the pipe to empty
	endtask

	task automatic runTest(input int i);
		int          startErr;
		logic [15:0] rd;
		startErr = errCnt;
		writeReg(ADDR_COLOR, tColor[i]);
		writeReg(ADDR_CTRL, tCtrl[i] | 16'h0200);   // Load alpha and clear count
		writeReg(ADDR_CTRL, tCtrl[i]);
		modelAlpha = tColor[i][15:12];
		modelCnt   = 0;
		streamFrames(tFrames[i], fadeCtrl_t'(tCtrl[i]), argb_t'(tColor[i]));
		checkVal("modelAlpha", {12'd0, tAlpha[i]}, {12'd0, modelAlpha});
		readReg(ADDR_STATUS, rd);
		checkVal("status", {14'd0, tMin[i], tMax[i]}, rd);
		reportTest(tName[i], startErr);
	endtask

	task automatic reportTest(input string name, input int startErr);
		if (errCnt == startErr)
		begin
			passCnt++;
			$display("Test %-14s passed", name);
		end
		else
		begin
			failCnt++;
			$display("Test %-14s failed, %0d errors", name, errCnt - startErr);
		end
	endtask

	task automatic setTest(input int i, input string name, input logic [15:0] color,
		input logic [15:0] ctrl, input int frames, input logic [3:0] alpha,
		input logic amax, input logic amin);
		tName[i]   = name;
		tColor[i]  = color;
		tCtrl[i]   = ctrl;
		tFrames[i] = frames;
		tAlpha[i]  = alpha;
		tMax[i]    = amax;
		tMin[i]    = amin;
	endtask

	// --------------------
	// Output check at mid cycle where outputs are settled
	always @(negedge iCLK)
	begin
		if (oValid === 1'b1)
		begin
			if (expQ.size() == 0)
			begin
				errCnt++;
				$display("Output strobe at %0t with no pixel expected", $time);
			end
			else
				checkVal("oPixel", expQ.pop_front(), oPixel);
		end
	end

	always @(posedge iCLK)
	begin
		cycleCnt++;
		if (cycleLimit != 0 && cycleCnt >= cycleLimit)
		begin
			$display("Timeout after %0d cycles, run did not complete", cycleCnt);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// --------------------
	// Main sequence
	initial
	begin
		int          startErr;
		logic [15:0] rd;
		rstN      = 1'b0;
		iCsrWe    = 1'b0;
		iCsrAddr  = ADDR_COLOR;
		iCsrWdata = '0;
		iSrcValid = 1'b0;
		iSrcPixel = '0;
		//           name            color     ctrl      frm  alpha  max   min
		setTest(0, "reset color", 16'h9A5F, 16'h0200, 2, 4'd9, 1'b0, 1'b0);
		setTest(1, "fade in", 16'h0F80, 16'h0081, 34, 4'd15, 1'b1, 1'b0);
		setTest(2, "fade out", 16'hF3C7, 16'h0101, 34, 4'd0, 1'b0, 1'b1);
		setTest(3, "random stream", 16'h32E9, 16'h0082, 9, 4'd6, 1'b0, 1'b0);
		for (int i = 0; i < cTests; i++)
			cycleLimit += tFrames[i] * 40;
		cycleLimit += 500;

		repeat (8) @(posedge iCLK);
		startErr = errCnt;
		checkVal("oValid", 16'd0, {15'd0, oValid});
		#1 rstN = 1'b1;
		readReg(ADDR_COLOR, rd);
		checkVal("color", 16'd0, rd);
		readReg(ADDR_CTRL, rd);
		checkVal("ctrl", 16'd0, rd);
		readReg(ADDR_STATUS, rd);
		checkVal("status", 16'd0, rd);
		reportTest("reset state", startErr);

		// Status address is read only
		startErr = errCnt;
		writeReg(ADDR_COLOR, 16'hA5C3);
		writeReg(ADDR_CTRL, 16'hFC05);
		writeReg(ADDR_STATUS, 16'hFFFF);
		readReg(ADDR_COLOR, rd);
		checkVal("color", 16'hA5C3, rd);
		readReg(ADDR_CTRL, rd);
		checkVal("ctrl", 16'hFC05, rd);
		readReg(ADDR_STATUS, rd);
		checkVal("status", 16'd0, rd);
		reportTest("readback", startErr);

		for (int i = 0; i < cTests; i++)
			runTest(i);

		$display("Tests passed %0d, failed %0d, errors %0d", passCnt, failCnt, errCnt);
		if (failCnt == 0 && errCnt == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== verif/fadeTop_assert.sv ====
// --------------------
// Fade overlay checks
// Bound to the top, watches flags and output strobe
// --------------------
`timescale 1ns/1ps

module fadeTopAssert (
	input logic iCLK,
	input logic rstN,
	input logic iSrcValid,
	input logic oValid,
	input logic alphaMax,
	input logic alphaMin
);

	// Fade cannot be done in both directions
	flagsExclusive : assert property (@(posedge iCLK) disable iff (!rstN)
		!(alphaMax && alphaMin))
		else $error("alphaMax and alphaMin both high");

	// Blender latency, strobe delayed by 2
	validLatency : assert property (@(posedge iCLK) disable iff (!rstN)
		oValid == $past(iSrcValid, 2))
		else $error("oValid does not follow iSrcValid by 2 cycles");

	validInReset : assert property (@(posedge iCLK) !rstN |-> !oValid)
		else $error("oValid high during reset");

endmodule

bind fadeTop fadeTopAssert i_fadeTopAssert (
	.iCLK      (iCLK),
	.rstN      (rstN),
	.iSrcValid (iSrcValid),
	.oValid    (oValid),
	.alphaMax  (alphaMax),
	.alphaMin  (alphaMin)
);

// ==== src/fadeTop.sv ====
// --------------------
// Fade overlay top
// Register block, frame counter, fade generator and blender
// --------------------
`timescale 1ns/1ps

module fadeTop #(
	parameter int pHActive = 8,    // Pixels per line
	parameter int pVActive = 4     // Lines per frame
)(
	input  logic              iCLK,
	input  logic              rstN,
	// Host port
	input  logic              iCsrWe,
	input  fadePkg::csrAddr_e iCsrAddr,
	input  fadePkg::csrData_u iCsrWdata,
	output logic [15:0]       oCsrRdata,
	// Pixel stream
	input  logic              iSrcValid,
	input  fadePkg::argb_t    iSrcPixel,
	output logic              oValid,
	output fadePkg::argb_t    oPixel
);

	import fadePkg::*;

	argb_t     sceneColor;    // CSR to generator
	fadeCtrl_t sceneCtrl;
	argb_t     scenePixel;    // Generator to blender
	logic      alphaMax;      // Status back to CSR
	logic      alphaMin;
	logic      frameEnd;

	// --------------------
	fadeCsr i_fadeCsr (
		.iCLK       (iCLK),
		.rstN       (rstN),
		.csrWe      (iCsrWe),
		.csrAddr    (iCsrAddr),
		.csrWdata   (iCsrWdata),
		.csrRdata   (oCsrRdata),
		.alphaMax   (alphaMax),
		.alphaMin   (alphaMin),
		.sceneColor (sceneColor),
		.sceneCtrl  (sceneCtrl)
	);

	// Frame end from the source stream
	frameCounter #(
		.pHActive (pHActive),
		.pVActive (pVActive)
	) i_frameCounter (
		.iCLK     (iCLK),
		.rstN     (rstN),
		.srcValid (iSrcValid),
		.frameEnd (frameEnd)
	);

	sceneChange i_sceneChange (
		.iCLK       (iCLK),
		.rstN       (rstN),
		.frameEnd   (frameEnd),
		.sceneColor (sceneColor),
		.sceneCtrl  (sceneCtrl),
		.scenePixel (scenePixel),
		.alphaMax   (alphaMax),
		.alphaMin   (alphaMin)
	);

	// Overlay over source, 2 cycles
	alphaBlend i_alphaBlend (
		.iCLK       (iCLK),
		.rstN       (rstN),
		.srcValid   (iSrcValid),
		.srcPixel   (iSrcPixel),
		.scenePixel (scenePixel),
		.outValid   (oValid),
		.outPixel   (oPixel)
	);

endmodule

// ==== src/alphaBlend.sv ====
// --------------------
// Alpha blender
// Two-stage pipe computing (a*scene + (15-a)*src) >> 4 per channel
// --------------------
`timescale 1ns/1ps

module alphaBlend (
	input  logic           iCLK,
	input  logic           rstN,
	input  logic           srcValid,     // Source pixel strobe
	input  fadePkg::argb_t srcPixel,
	input  fadePkg::argb_t scenePixel,   // Overlay whose alpha is the weight
	output logic           outValid,     // srcValid delayed by 2
	output fadePkg::argb_t outPixel
);

	import fadePkg::*;

	logic [3:0]      alphaInv;     // 15 - a
	logic [2:0][3:0] sceneCh;      // {red, green, blue}
	logic [2:0][3:0] srcCh;
	logic [2:0][7:0] sceneProd;    // Stage 1 product a * scene
	logic [2:0][7:0] srcProd;      // Stage 1 product (15-a) * src
	logic [2:0][7:0] chSum;        // At most 225 so 8 bits suffice
	logic [2:0][3:0] blendCh;      // Sum >> 4
	logic [1:0]      validPipe;

	assign alphaInv = ALPHA_MAX - scenePixel.alpha;
	assign sceneCh  = {scenePixel.red, scenePixel.green, scenePixel.blue};
	assign srcCh    = {srcPixel.red, srcPixel.green, srcPixel.blue};

	// --------------------
	// Stage 1 per-channel products
	always_ff @(posedge iCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			sceneProd <= '0;
			srcProd   <= '0;
		end
		else
		begin
			for (int i = 0; i < 3; i++)
			begin
				sceneProd[i] <= scenePixel.alpha * sceneCh[i];
				srcProd[i]   <= alphaInv * srcCh[i];
			end
		end
	end

	// Sum and scale
	always_comb
	begin
		for (int i = 0; i < 3; i++)
		begin
			chSum[i]   = sceneProd[i] + srcProd[i];
			blendCh[i] = chSum[i][7:4];
		end
	end

	// --------------------
	// Stage 2 output with opaque alpha
	always_ff @(posedge iCLK or negedge rstN)
	begin
		if (!rstN)
			outPixel <= '0;
		else
			outPixel <= {ALPHA_MAX, blendCh};
	end

	// Strobe travels beside the data
	always_ff @(posedge iCLK or negedge rstN)
	begin
		if (!rstN)
			validPipe <= '0;
		else
			validPipe <= {validPipe[0], srcValid};
	end

	assign outValid = validPipe[1];

endmodule

// ==== src/sceneChange.sv ====
// --------------------
// Fade generator
// Steps the overlay alpha by one every frameTiming+1 frames,
// up or down, and flags the ends of the fade
// --------------------
`timescale 1ns/1ps

module sceneChange (
	input  logic               iCLK,
	input  logic               rstN,
	input  logic               frameEnd,     // Pulse on last pixel of frame
	input  fadePkg::argb_t     sceneColor,   // Programmed overlay color
	input  fadePkg::fadeCtrl_t sceneCtrl,
	output fadePkg::argb_t     scenePixel,   // Overlay pixel to the blender
	output logic               alphaMax,     // Fade in done
	output logic               alphaMin      // Fade out done
);

	import fadePkg::*;

	logic [6:0] frameCnt;     // Frames since last step
	logic       fadeRun;      // Either direction enabled
	logic       fadeUp;       // Add wins over sub
	logic       fadeDown;
	logic       stepEn;       // Count reached frameTiming
	logic       stepNow;      // Step on this frame end
	logic       atMax;
	logic       atMin;

	// --------------------
	// Direction decode, reset has priority over add, add over sub
	assign fadeRun  = !sceneCtrl.sceneRst && (sceneCtrl.addEn || sceneCtrl.subEn);
	assign fadeUp   = !sceneCtrl.sceneRst && sceneCtrl.addEn;
	assign fadeDown = !sceneCtrl.sceneRst && !sceneCtrl.addEn && sceneCtrl.subEn;

	assign stepEn  = (frameCnt == sceneCtrl.frameTiming);
	assign stepNow = frameEnd && fadeRun && stepEn;

	assign atMax = (scenePixel.alpha == ALPHA_MAX);
	assign atMin = (scenePixel.alpha == 4'd0);

	// Frame counter
	always_ff @(posedge iCLK or negedge rstN)
	begin
		if (!rstN)
			frameCnt <= '0;
		else if (sceneCtrl.sceneRst)
			frameCnt <= '0;                    // Held clear during reset
		else if (frameEnd && fadeRun)
		begin
			if (stepEn)
				frameCnt <= '0;                // Step frame, restart count
			else
				frameCnt <= frameCnt + 1'b1;
		end
	end

	// --------------------
	// Alpha step, saturating at both ends
	always_ff @(posedge iCLK or negedge rstN)
	begin
		if (!rstN)
			scenePixel.alpha <= '0;
		else if (sceneCtrl.sceneRst)
			scenePixel.alpha <= sceneColor.alpha;  // Load every cycle
		else if (stepNow)
		begin
			if (fadeUp && !atMax)
				scenePixel.alpha <= scenePixel.alpha + 1'b1;
			else if (fadeDown && !atMin)
				scenePixel.alpha <= scenePixel.alpha - 1'b1;
		end
	end

	// Color fields never step, they keep the programmed color
	always_ff @(posedge iCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			scenePixel.red   <= '0;
			scenePixel.green <= '0;
			scenePixel.blue  <= '0;
		end
		else
		begin
			scenePixel.red   <= sceneColor.red;
			scenePixel.green <= sceneColor.green;
			scenePixel.blue  <= sceneColor.blue;
		end
	end

	// --------------------
	// End flags, one cycle behind the alpha value
	// Only raised in the running direction
	always_ff @(posedge iCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			alphaMax <= 1'b0;
			alphaMin <= 1'b0;
		end
		else
		begin
			alphaMax <= fadeUp && atMax;
			alphaMin <= fadeDown && atMin;
		end
	end

endmodule

// ==== src/fadeCsr.sv ====
// --------------------
// Fade register block
// Holds overlay color and control word for the host,
// returns color, control or status one cycle after the address
// --------------------
`timescale 1ns/1ps

module fadeCsr (
	input  logic               iCLK,
	input  logic               rstN,
	input  logic               csrWe,       // One-cycle write strobe
	input  fadePkg::csrAddr_e  csrAddr,     // Shared by read and write
	input  fadePkg::csrData_u  csrWdata,
	output logic [15:0]        csrRdata,    // Registered read data
	input  logic               alphaMax,    // Live flags from fade generator
	input  logic               alphaMin,
	output fadePkg::argb_t     sceneColor,
	output fadePkg::fadeCtrl_t sceneCtrl
);

	import fadePkg::*;

	logic        colorWe;      // Write hits color register
	logic        ctrlWe;       // Write hits control register
	logic [15:0] statusWord;   // Flags as seen by the host
	logic [15:0] rdNext;       // Read mux output

	// --------------------
	// Write decode
	// Status address decodes to nothing
	assign colorWe = csrWe && (csrAddr == ADDR_COLOR);
	assign ctrlWe  = csrWe && (csrAddr == ADDR_CTRL);

	// Color view of the write word
	always_ff @(posedge iCLK or negedge rstN)
	begin
		if (!rstN)
			sceneColor <= '0;
		else if (colorWe)
			sceneColor <= csrWdata.color;
	end

	// Control view of the write word
	always_ff @(posedge iCLK or negedge rstN)
	begin
		if (!rstN)
			sceneCtrl <= '0;
		else if (ctrlWe)
			sceneCtrl <= csrWdata.ctrl;   // Reserved bits kept as written
	end

	// --------------------
	// Read path
	assign statusWord = {14'd0, alphaMin, alphaMax};

	always_comb
	begin
		case (csrAddr)
			ADDR_COLOR:  rdNext = sceneColor;
			ADDR_CTRL:   rdNext = sceneCtrl;
			ADDR_STATUS: rdNext = statusWord;
			default:     rdNext = '0;       // Unmapped address
		endcase
	end

	// Address sampled every cycle, data one cycle later
	always_ff @(posedge iCLK or negedge rstN)
	begin
		if (!rstN)
			csrRdata <= '0;
		else
			csrRdata <= rdNext;
	end

endmodule

// ==== src/frameCounter.sv ====
// --------------------
// Frame counter
// Tracks pixel position in the source stream and
// pulses frameEnd on the last valid pixel of a frame
// --------------------
`timescale 1ns/1ps

module frameCounter #(
	parameter int pHActive = 8,    // Pixels per line
	parameter int pVActive = 4     // Lines per frame
)(
	input  logic iCLK,
	input  logic rstN,
	input  logic srcValid,         // One strobe per source pixel
	output logic frameEnd          // High with the last pixel of the frame
);

	// Counter widths, at least one bit each
	localparam int cColW = (pHActive > 1) ? $clog2(pHActive) : 1;
	localparam int cRowW = (pVActive > 1) ? $clog2(pVActive) : 1;

	localparam logic [cColW-1:0] cColLast = cColW'(pHActive - 1);
	localparam logic [cRowW-1:0] cRowLast = cRowW'(pVActive - 1);

	logic [cColW-1:0] colCnt;      // Pixel within line
	logic [cRowW-1:0] rowCnt;      // Line within frame
	logic             lineLast;    // Column at line end
	logic             rowLast;     // Row at frame end

	assign lineLast = (colCnt == cColLast);
	assign rowLast  = (rowCnt == cRowLast);

	// --------------------
	// Column counter
	always_ff @(posedge iCLK or negedge rstN)
	begin
		if (!rstN)
			colCnt <= '0;
		else if (srcValid)
		begin
			if (lineLast)
				colCnt <= '0;              // Wrap at line end
			else
				colCnt <= colCnt + 1'b1;
		end
	end

	// Line counter, moves on the last pixel of each line
	always_ff @(posedge iCLK or negedge rstN)
	begin
		if (!rstN)
			rowCnt <= '0;
		else if (srcValid && lineLast)
		begin
			if (rowLast)
				rowCnt <= '0;              // Wrap at frame end
			else
				rowCnt <= rowCnt + 1'b1;
		end
	end

	// --------------------
	// Same cycle as the last strobe, no added latency
	assign frameEnd = srcValid && lineLast && rowLast;

endmodule

// ==== src/fadePkg.sv ====
// --------------------
// Fade overlay shared types
// Pixel word, control word, host write union and register map
// --------------------
package fadePkg;

	// Top of the 4-bit alpha field
	localparam logic [3:0] ALPHA_MAX = 4'd15;

	// --------------------
	// Pixel word, ARGB 4:4:4:4
	typedef struct packed {
		logic [3:0] alpha;    // Overlay weight, 0 transparent
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} argb_t;

	// --------------------
	// Fade control word
	typedef struct packed {
		logic [5:0] reserved;    // Kept for readback only
		logic       sceneRst;    // Hold overlay at programmed color
		logic       subEn;       // Fade toward alpha 0
		logic       addEn;       // Fade toward alpha 15, wins over subEn
		logic [6:0] frameTiming; // Frames per step minus one
	} fadeCtrl_t;

	// Host write word, view picked by address
	typedef union packed {
		argb_t     color;
		fadeCtrl_t ctrl;
	} csrData_u;

	// Register map
	typedef enum logic [1:0] {
		ADDR_COLOR  = 2'd0,
		ADDR_CTRL   = 2'd1,
		ADDR_STATUS = 2'd2     // Read only, {alphaMin, alphaMax}
	} csrAddr_e;

endpackage
